// File: build.f
hdl/motor_pkg.sv
hdl/control_timer.sv
hdl/tach_counter.sv
hdl/loop_fsm.sv
hdl/speed_controller.sv
hdl/pwm_gen.sv
hdl/speed_loop_top.sv
dv/speed_loop_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP       := speed_loop_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
PASS_MSG  := Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/speed_loop_tb.sv
`timescale 1ns/1ps

module speed_loop_tb import motor_pkg::*; ();

	localparam int ROWS            = 7;
	localparam int PERIODS_PER_ROW = 4;
	localparam int HS_WAIT         = 16;                    // cycles allowed for ack edges
	localparam int SETTLE          = 2 * PWM_PERIOD + 8;    // disable reaches the pwm line
	localparam int PWM_START       = PWM_PERIOD + 8;        // new duty latched by then
	localparam int TIMEOUT_CYCLES  = ROWS * PERIODS_PER_ROW * CTRL_PERIOD + 2 * CTRL_PERIOD;

	logic              clk;
	logic              reset;
	logic              i_motor_en;
	logic              i_tach_pulse;
	logic              i_req;
	logic [RPM_W-1:0]  i_rpm_setpoint;
	logic              o_ack;
	logic              o_update;
	logic              o_motor_pwm;
	logic [DUTY_W-1:0] o_duty;
	logic [RPM_W-1:0]  o_rpm_measured;

	// stimulus table columns are enable, setpoint and tach period in clocks (0 = no pulses)
	bit en_tab  [ROWS] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};
	int sp_tab  [ROWS] = '{40, 200, 0, 0, 100, 50, 0};
	int per_tab [ROWS] = '{16, 8, 4, 2, 10, 0, 12};

	int   seed;
	int   tach_per;   // tach period of the current row
	int   model_sp;   // setpoint the DUT holds
	logic hs_busy;
	int   tach_phase;
	int   edge_cnt;   // edges driven since the last update
	int   exp_duty;
	bit   hs_seen;
	int   dis_cycles;
	int   since_upd;
	int   pwm_high;
	bit   pwm_valid;
	int   cycle_cnt;

	speed_loop_top dut0 (
		.clk           (clk           ),
		.reset         (reset         ),
		.i_motor_en    (i_motor_en    ),
		.i_tach_pulse  (i_tach_pulse  ),
		.i_req         (i_req         ),
		.i_rpm_setpoint(i_rpm_setpoint),
		.o_ack         (o_ack         ),
		.o_update      (o_update      ),
		.o_motor_pwm   (o_motor_pwm   ),
		.o_duty        (o_duty        ),
		.o_rpm_measured(o_rpm_measured)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped on the first failure");
	endtask

	task automatic check_value(input string name, input int exp_v, input int got_v);
		assert (got_v == exp_v) else begin
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
			stop_run();
		end
	endtask

	// measured speed may be off by one edge from the window shift
	task automatic check_near(input string name, input int exp_v, input int got_v);
		assert (got_v - exp_v <= 1 && exp_v - got_v <= 1) else begin
			$display("[ERROR] %0t %s expected %0d (+/-1) got %0d", $time, name, exp_v, got_v);
			stop_run();
		end
	endtask

	// four-phase setpoint load with bounded waits
	task automatic load_setpoint(input int sp);
		int waited;
		check_value("o_ack", 0, o_ack);
		hs_busy        <= 1'b1;
		i_rpm_setpoint <= RPM_W'(sp);
		i_req          <= 1'b1;
		waited = 0;
		@(negedge clk);
		while (!o_ack && waited < HS_WAIT) begin
			@(negedge clk);
			waited++;
		end
		assert (o_ack) else begin
			$display("no acknowledge within %0d cycles of the setpoint request", HS_WAIT);
			stop_run();
		end
		model_sp <= sp;
		repeat (3) begin
			@(negedge clk);
			check_value("o_ack", 1, o_ack); // held while req is high
		end
		i_req <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (o_ack && waited < HS_WAIT) begin
			@(negedge clk);
			waited++;
		end
		assert (!o_ack) else begin
			$display("acknowledge still high %0d cycles after the request fell", HS_WAIT);
			stop_run();
		end
		hs_busy <= 1'b0;
	endtask

	// reference model and output checks on every falling edge
	task automatic watch_outputs();
		int exp_rpm;
		int sum;
		if (hs_busy) hs_seen = 1'b1;
		if (!i_motor_en) begin
			dis_cycles++;
			exp_duty  = 0; // duty forced off
			pwm_valid = 1'b0;
		end else begin
			dis_cycles = 0;
		end
		if (dis_cycles > SETTLE) begin
			check_value("o_update", 0, o_update);
			check_value("o_duty", 0, o_duty);
			check_value("o_motor_pwm", 0, o_motor_pwm);
		end
		if (o_update) begin
			if (i_motor_en) begin
				exp_rpm = (edge_cnt > RPM_MAX) ? RPM_MAX : edge_cnt;
				if (!hs_seen) check_near("o_rpm_measured", exp_rpm, o_rpm_measured);
				sum = exp_duty + (((model_sp - int'(o_rpm_measured)) * KP_NUM) >>> KP_SHIFT);
				if (sum < 0) sum = 0;
				else if (sum > DUTY_MAX) sum = DUTY_MAX;
				exp_duty = sum;
				check_value("o_duty", exp_duty, o_duty);
			end
			edge_cnt  = 0;
			hs_seen   = hs_busy;
			since_upd = 0;
			pwm_high  = 0;
			pwm_valid = i_motor_en;
		end else begin
			since_upd++;
		end
		// one full pwm period once the duty is latched
		if (since_upd >= PWM_START && since_upd < PWM_START + PWM_PERIOD) begin
			if (o_motor_pwm) pwm_high++;
			if (since_upd == PWM_START + PWM_PERIOD - 1 && pwm_valid)
				check_value("o_motor_pwm high cycles", exp_duty, pwm_high);
		end
	endtask

	task automatic drive_tach();
		logic next;
		next = 1'b0;
		if (tach_per > 0) begin
			tach_phase = (tach_phase + 1) % tach_per;
			next       = (tach_phase < tach_per / 2);
		end
		if (next && !i_tach_pulse) edge_cnt++;
		i_tach_pulse <= next;
	endtask

	always @(negedge clk) begin
		if (!reset) begin
			watch_outputs();
			drive_tach(); // after the checks so the edge count stays in order
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			stop_run();
		end
	end

	initial begin
		reset          = 1'b1;
		i_motor_en     = 1'b0;
		i_tach_pulse   = 1'b0;
		i_req          = 1'b0;
		i_rpm_setpoint = '0;
		tach_per       = 0;
		model_sp       = 0;
		hs_busy        = 1'b0;
		tach_phase     = 0;
		edge_cnt       = 0;
		exp_duty       = 0;
		hs_seen        = 1'b0;
		dis_cycles     = 0;
		since_upd      = 0;
		pwm_high       = 0;
		pwm_valid      = 1'b0;
		cycle_cnt      = 0;
		seed           = 32'hba9ad726;
		sp_tab[3]      = $unsigned($random(seed)) % 256;
		sp_tab[6]      = $unsigned($random(seed)) % 256;

		repeat (8) @(negedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("o_ack", 0, o_ack);
		check_value("o_update", 0, o_update);
		check_value("o_motor_pwm", 0, o_motor_pwm);
		check_value("o_duty", 0, o_duty);
		check_value("o_rpm_measured", 0, o_rpm_measured);

		for (int r = 0; r < ROWS; r++) begin
			@(negedge clk);
			i_motor_en <= en_tab[r];
			tach_per   <= per_tab[r];
			load_setpoint(sp_tab[r]);
			repeat (PERIODS_PER_ROW * CTRL_PERIOD) @(negedge clk);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: hdl/speed_loop_top.sv
`timescale 1ns/1ps

module speed_loop_top import motor_pkg::*; (
	input  logic              clk           ,
	input  logic              reset         ,
	input  logic              i_motor_en    ,
	input  logic              i_tach_pulse  ,
	input  logic              i_req         ,
	input  logic [RPM_W-1:0]  i_rpm_setpoint,
	output logic              o_ack         ,
	output logic              o_update      ,
	output logic              o_motor_pwm   ,
	output logic [DUTY_W-1:0] o_duty        ,
	output logic [RPM_W-1:0]  o_rpm_measured
);

	logic tick;
	logic sample;
	logic step;
	logic load_sp;
	logic run;

	control_timer u_control_timer (
		.clk   (clk  ),
		.reset (reset),
		.o_tick(tick )
	);

	tach_counter u_tach_counter (
		.clk           (clk           ),
		.reset         (reset         ),
		.i_tach_pulse  (i_tach_pulse  ),
		.i_sample      (sample        ),
		.o_rpm_measured(o_rpm_measured)
	);

	loop_fsm u_loop_fsm (
		.clk       (clk       ),
		.reset     (reset     ),
		.i_motor_en(i_motor_en),
		.i_tick    (tick      ),
		.i_req     (i_req     ),
		.o_sample  (sample    ),
		.o_step    (step      ),
		.o_load_sp (load_sp   ),
		.o_run     (run       ),
		.o_ack     (o_ack     ),
		.o_update  (o_update  )
	);

	speed_controller u_speed_controller (
		.clk           (clk           ),
		.reset         (reset         ),
		.i_rpm_setpoint(i_rpm_setpoint),
		.i_load_sp     (load_sp       ),
		.i_step        (step          ),
		.i_run         (run           ),
		.i_rpm_measured(o_rpm_measured),
		.o_duty        (o_duty        )
	);

	pwm_gen u_pwm_gen (
		.clk        (clk        ),
		.reset      (reset      ),
		.i_duty     (o_duty     ),
		.o_motor_pwm(o_motor_pwm)
	);

endmodule

// File: hdl/pwm_gen.sv
`timescale 1ns/1ps

module pwm_gen import motor_pkg::*; (
	input  logic              clk        ,
	input  logic              reset      ,
	input  logic [DUTY_W-1:0] i_duty     ,
	output logic              o_motor_pwm
);

	logic [DUTY_W-2:0] cnt;    // counts 0 .. PWM_PERIOD-1 in one bit less than duty
	logic [DUTY_W-1:0] duty_q; // duty in force for this period
	logic              wrap;

	assign wrap = (cnt == (DUTY_W - 1)'(PWM_PERIOD - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt    <= '0;
			duty_q <= '0;
		end else begin
			cnt <= wrap ? '0 : cnt + 1'b1;
			// new duty only at the period boundary
			if (wrap) begin
				duty_q <= i_duty;
			end
		end
	end

	// duty of DUTY_MAX keeps the line high for the whole period
	assign o_motor_pwm = ({1'b0, cnt} < duty_q);

endmodule

// File: hdl/speed_controller.sv
`timescale 1ns/1ps

module speed_controller import motor_pkg::*; (
	input  logic              clk           ,
	input  logic              reset         ,
	input  logic [RPM_W-1:0]  i_rpm_setpoint,
	input  logic              i_load_sp     , // capture the host setpoint
	input  logic              i_step        , // one control step
	input  logic              i_run         ,
	input  logic [RPM_W-1:0]  i_rpm_measured,
	output logic [DUTY_W-1:0] o_duty        
);

	logic        [RPM_W-1:0]  sp_q;
	logic        [DUTY_W-1:0] duty_q;
	logic        [DUTY_W-1:0] duty_next;
	logic signed [ERR_W-1:0]  err;
	logic signed [PROD_W-1:0] prod;
	logic signed [PROD_W-1:0] offset;
	logic signed [PROD_W-1:0] sum;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sp_q <= '0;
		end else if (i_load_sp) begin
			sp_q <= i_rpm_setpoint;
		end
	end

	// proportional term only
	always_comb begin
		err    = $signed({1'b0, sp_q}) - $signed({1'b0, i_rpm_measured});
		prod   = PROD_W'(err * KP_NUM);
		offset = prod >>> KP_SHIFT; // floors toward minus infinity
		sum    = offset + $signed({{(PROD_W - DUTY_W){1'b0}}, duty_q});

		// clamp to 0 .. DUTY_MAX
		if (sum < 0) begin
			duty_next = '0;
		end else if (sum > DUTY_MAX) begin
			duty_next = DUTY_W'(DUTY_MAX);
		end else begin
			duty_next = sum[DUTY_W-1:0];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			duty_q <= '0;
		end else if (!i_run) begin
			duty_q <= '0; // motor off
		end else if (i_step) begin
			duty_q <= duty_next;
		end
	end

	assign o_duty = duty_q;

endmodule

// File: hdl/loop_fsm.sv
`timescale 1ns/1ps

module loop_fsm import motor_pkg::*; (
	input  logic clk       ,
	input  logic reset     ,
	input  logic i_motor_en, // motor enable switch
	input  logic i_tick    ,
	input  logic i_req     , // setpoint request from host
	output logic o_sample  ,
	output logic o_step    ,
	output logic o_load_sp ,
	output logic o_run     ,
	output logic o_ack     ,
	output logic o_update  
);

	logic [STATE_W-1:0] state;
	logic [STATE_W-1:0] state_next;
	logic               run_q;
	logic               run_next;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			run_q <= 1'b0;
		end else begin
			state <= state_next;
			run_q <= run_next;
		end
	end

	always_comb begin
		state_next = state;
		run_next   = run_q;
		case (state)
			ST_IDLE: begin
				if (i_req) begin
					state_next = ST_LOAD; // handshake served even when disabled
				end else if (i_motor_en) begin
					state_next = ST_RUN;
					run_next   = 1'b1;
				end
			end
			ST_RUN: begin
				if (!i_motor_en) begin
					state_next = ST_IDLE;
					run_next   = 1'b0;
				end else if (i_tick) begin
					state_next = ST_SAMPLE; // tick wins over a new request
				end else if (i_req) begin
					state_next = ST_LOAD;
				end
			end
			ST_SAMPLE: state_next = ST_STEP;
			ST_STEP: begin
				if (!i_motor_en) begin
					state_next = ST_IDLE;
					run_next   = 1'b0;
				end else begin
					state_next = ST_RUN;
				end
			end
			ST_LOAD: state_next = ST_ACK;
			ST_ACK: begin
				// ticks seen here are dropped
				if (!i_req) begin
					if (run_q && i_motor_en) begin
						state_next = ST_RUN;
					end else begin
						state_next = ST_IDLE;
						run_next   = 1'b0;
					end
				end
			end
			default: begin
				state_next = ST_IDLE;
				run_next   = 1'b0;
			end
		endcase
	end

	assign o_sample  = (state == ST_SAMPLE);
	assign o_step    = (state == ST_STEP);
	assign o_load_sp = (state == ST_LOAD);
	assign o_ack     = (state == ST_ACK);
	assign o_run     = run_q;

	// update flag lines up with the new duty
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_update <= 1'b0;
		end else begin
			o_update <= o_step;
		end
	end

endmodule

// File: hdl/tach_counter.sv
`timescale 1ns/1ps

module tach_counter import motor_pkg::*; (
	input  logic             clk           ,
	input  logic             reset         ,
	input  logic             i_tach_pulse  , // async tachometer line
	input  logic             i_sample      , // closes the current window
	output logic [RPM_W-1:0] o_rpm_measured
);

	logic             tach_meta;
	logic             tach_sync;
	logic             tach_prev;
	logic             tach_rise;
	logic [RPM_W-1:0] edge_cnt;
	logic             cnt_full;

	// two-flop synchroniser plus a delay flop for edge detect
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			tach_meta <= 1'b0;
			tach_sync <= 1'b0;
			tach_prev <= 1'b0;
		end else begin
			tach_meta <= i_tach_pulse;
			tach_sync <= tach_meta;
			tach_prev <= tach_sync;
		end
	end

	assign tach_rise = tach_sync & ~tach_prev;
	assign cnt_full  = (edge_cnt == RPM_W'(RPM_MAX));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			edge_cnt       <= '0;
			o_rpm_measured <= '0;
		end else if (i_sample) begin
			o_rpm_measured <= edge_cnt;
			// an edge in the sample cycle opens the new window
			edge_cnt       <= tach_rise ? RPM_W'(1) : '0;
		end else if (tach_rise && !cnt_full) begin
			edge_cnt <= edge_cnt + 1'b1;
		end
	end

endmodule

// File: hdl/control_timer.sv
`timescale 1ns/1ps

module control_timer import motor_pkg::*; (
	input  logic clk   ,
	input  logic reset ,
	output logic o_tick  // one cycle per control period
);

	logic [CTRL_CNT_W-1:0] cnt;
	logic                  wrap;

	assign wrap = (cnt == CTRL_CNT_W'(CTRL_PERIOD - 1));

	// free-running period counter
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// registered tick on the wrap
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			o_tick <= 1'b0;
		end else begin
			o_tick <= wrap;
		end
	end

endmodule

// File: hdl/motor_pkg.sv
package motor_pkg;

	// speed and setpoint in tach pulses per control window
	localparam int RPM_W   = 8;
	localparam int ERR_W   = RPM_W + 1; // signed error needs one more bit
	localparam int RPM_MAX = 255;        // edge count saturates here

	// duty cycle wide enough to hold the full period
	localparam int DUTY_W     = 7;
	localparam int PWM_PERIOD = 64;
	localparam int DUTY_MAX   = PWM_PERIOD; // output stuck high

	// control tick divider sized for simulation
	localparam int CTRL_PERIOD = 512;
	localparam int CTRL_CNT_W  = 9;

	// proportional gain = KP_NUM / 2**KP_SHIFT
	localparam int KP_NUM   = 3;
	localparam int KP_SHIFT = 2;
	localparam int PROD_W   = ERR_W + 3; // error times gain with headroom

	// speed loop fsm encodings
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE   = 3'd0;
	localparam logic [STATE_W-1:0] ST_RUN    = 3'd1;
	localparam logic [STATE_W-1:0] ST_SAMPLE = 3'd2;
	localparam logic [STATE_W-1:0] ST_STEP   = 3'd3;
	localparam logic [STATE_W-1:0] ST_LOAD   = 3'd4;
	localparam logic [STATE_W-1:0] ST_ACK    = 3'd5;

endpackage
